// File: verilog/mem_pkg.sv
package mem_pkg;

    // widths seen on the cache side and by the reorder buffer

    // byte address
    typedef logic [31:0] addr_t;

    // one load or store value, word wide
    typedef logic [31:0] data_t;

    // access size code, same encoding the cache uses
    typedef logic [1:0] mem_size_t;

    // reorder-buffer tag carried with every memory op
    typedef logic [4:0] rob_tag_t;

endpackage

// File: verilog/queue_pkg.sv
package queue_pkg;

    // queue geometry, depth must stay a power of two
    localparam int LSQ_DEPTH = 8;
    localparam int LSQ_INDEX_BITS = $clog2(LSQ_DEPTH);

    // entry slot
    typedef logic [LSQ_INDEX_BITS-1:0] lsq_index_t;

    // slot plus wrap bit, tells full from empty
    typedef logic [LSQ_INDEX_BITS:0] lsq_ptr_t;

    // one bit per slot
    typedef logic [LSQ_DEPTH-1:0] lsq_mask_t;

    // oldest set bit of req, counting from head in program order
    function automatic lsq_index_t oldest_index(lsq_mask_t req, lsq_index_t head);
        lsq_index_t slot;
        lsq_index_t pick;
        pick = head;
        // walk from youngest to oldest so the oldest hit is kept
        for (int k = LSQ_DEPTH - 1; k >= 0; k--) begin
            slot = head + lsq_index_t'(k);
            if (req[slot]) begin
                pick = slot;
            end
        end
        return pick;
    endfunction

endpackage

// File: verilog/lsq_dispatch.sv
module lsq_dispatch
    import queue_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic       dispatch_valid,
    input  logic       dispatch_is_load,
    input  rob_tag_t   dispatch_tag,
    input  logic       free_head,
    output lsq_index_t dispatch_index,
    output logic       full,
    output logic       alloc_strobe,
    output lsq_index_t alloc_index,
    output lsq_mask_t  occupied,
    output lsq_mask_t  is_load,
    output lsq_ptr_t   head,
    output rob_tag_t [LSQ_DEPTH-1:0] tags
);

    lsq_ptr_t   tail;
    lsq_index_t head_idx;
    lsq_index_t tail_idx;

    assign head_idx = head[LSQ_INDEX_BITS-1:0];
    assign tail_idx = tail[LSQ_INDEX_BITS-1:0];

    // same slot, different lap means every entry is taken
    assign full = (head_idx == tail_idx) && (head[LSQ_INDEX_BITS] != tail[LSQ_INDEX_BITS]);

    // new op always lands at the tail
    assign dispatch_index = tail_idx;
    assign alloc_index = tail_idx;

    // dispatch while full is illegal, drop it here anyway
    assign alloc_strobe = dispatch_valid && !full;

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            occupied <= '0;
        end else begin
            // head entry leaves the queue
            if (free_head) begin
                occupied[head_idx] <= 1'b0;
                head <= head + 1'b1;
            end
            if (alloc_strobe) begin
                occupied[tail_idx] <= 1'b1;
                tail <= tail + 1'b1;
            end
        end
    end

    // kind and rob tag per slot
    always_ff @(posedge clock) begin
        if (alloc_strobe) begin
            is_load[tail_idx] <= dispatch_is_load;
            tags[tail_idx] <= dispatch_tag;
        end
    end

endmodule

// File: verilog/lsq_address_file.sv
module lsq_address_file
    import queue_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic       alloc_strobe,
    input  lsq_index_t alloc_index,
    input  logic       exec_valid,
    input  lsq_index_t exec_index,
    input  addr_t      exec_addr,
    input  mem_size_t  exec_size,
    input  data_t      exec_data,
    output lsq_mask_t  addr_known,
    output addr_t     [LSQ_DEPTH-1:0] addrs,
    output mem_size_t [LSQ_DEPTH-1:0] sizes,
    output data_t     [LSQ_DEPTH-1:0] store_data
);

    // known flag per slot
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            addr_known <= '0;
        end else begin
            // fresh entry has no address yet
            if (alloc_strobe) begin
                addr_known[alloc_index] <= 1'b0;
            end
            // execute result arrives later, wins on a tie
            if (exec_valid) begin
                addr_known[exec_index] <= 1'b1;
            end
        end
    end

    // address, size and data
    // loads write data too, nobody reads it
    always_ff @(posedge clock) begin
        if (exec_valid) begin
            addrs[exec_index] <= exec_addr;
            sizes[exec_index] <= exec_size;
            store_data[exec_index] <= exec_data;
        end
    end

endmodule

// File: verilog/lsq_load_resolve.sv
module lsq_load_resolve
    import queue_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic       alloc_strobe,
    input  lsq_index_t alloc_index,
    input  lsq_mask_t  occupied,
    input  lsq_mask_t  is_load,
    input  lsq_ptr_t   head,
    input  lsq_mask_t  addr_known,
    input  addr_t     [LSQ_DEPTH-1:0] addrs,
    input  mem_size_t [LSQ_DEPTH-1:0] sizes,
    input  data_t     [LSQ_DEPTH-1:0] store_data,
    input  logic       load_req_accept,
    input  logic       cache_resp_valid,
    input  addr_t      cache_resp_addr,
    input  data_t      cache_resp_data,
    output logic       load_req_valid,
    output lsq_index_t load_req_index,
    output lsq_mask_t  load_done,
    output data_t [LSQ_DEPTH-1:0] load_values
);

    lsq_index_t head_idx;
    // load already on its way to the cache
    lsq_mask_t  sent;
    // forward hit, cache candidate, response match
    lsq_mask_t  fwd_hit;
    lsq_mask_t  cand;
    lsq_mask_t  resp_hit;
    data_t [LSQ_DEPTH-1:0] fwd_data;

    assign head_idx = head[LSQ_INDEX_BITS-1:0];

    // per load ordering search
    always_comb begin
        lsq_index_t age_i;
        lsq_index_t age_j;
        lsq_index_t slot;
        lsq_index_t src;
        lsq_mask_t  older_st;
        logic       blocked;
        logic       found;
        logic       ready;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            // age relative to head, wrap handled by slot arithmetic
            age_i = lsq_index_t'(i) - head_idx;
            for (int j = 0; j < LSQ_DEPTH; j++) begin
                age_j = lsq_index_t'(j) - head_idx;
                older_st[j] = occupied[j] && !is_load[j] && (age_j < age_i);
            end
            // any older store without address stalls the load
            blocked = |(older_st & ~addr_known);
            // youngest older store with same address and size
            found = 1'b0;
            src = head_idx;
            for (int k = 0; k < LSQ_DEPTH; k++) begin
                slot = head_idx + lsq_index_t'(k);
                if (older_st[slot] && addrs[slot] == addrs[i] && sizes[slot] == sizes[i]) begin
                    found = 1'b1;
                    src = slot;
                end
            end
            ready = occupied[i] && is_load[i] && addr_known[i] && !load_done[i] && !blocked;
            fwd_hit[i] = ready && found;
            fwd_data[i] = store_data[src];
            // no match, go to the cache once
            cand[i] = ready && !found && !sent[i];
            // response is matched by address only
            resp_hit[i] = cache_resp_valid && occupied[i] && sent[i] && !load_done[i]
                          && addrs[i] == cache_resp_addr;
        end
    end

    // oldest candidate goes first
    assign load_req_valid = |cand;
    assign load_req_index = oldest_index(cand, head_idx);

    // sent and done flags
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            sent <= '0;
            load_done <= '0;
        end else begin
            if (alloc_strobe) begin
                sent[alloc_index] <= 1'b0;
                load_done[alloc_index] <= 1'b0;
            end
            if (load_req_accept) begin
                sent[load_req_index] <= 1'b1;
            end
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (fwd_hit[i] || resp_hit[i]) begin
                    load_done[i] <= 1'b1;
                end
            end
        end
    end

    // load result, forwarded value first
    always_ff @(posedge clock) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (fwd_hit[i]) begin
                load_values[i] <= fwd_data[i];
            end else if (resp_hit[i]) begin
                load_values[i] <= cache_resp_data;
            end
        end
    end

endmodule

// File: verilog/lsq_commit.sv
module lsq_commit
    import queue_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic       alloc_strobe,
    input  lsq_index_t alloc_index,
    input  lsq_mask_t  occupied,
    input  lsq_mask_t  is_load,
    input  lsq_ptr_t   head,
    input  rob_tag_t  [LSQ_DEPTH-1:0] tags,
    input  addr_t     [LSQ_DEPTH-1:0] addrs,
    input  mem_size_t [LSQ_DEPTH-1:0] sizes,
    input  data_t     [LSQ_DEPTH-1:0] store_data,
    input  lsq_mask_t  load_done,
    input  data_t     [LSQ_DEPTH-1:0] load_values,
    input  logic       load_req_valid,
    input  lsq_index_t load_req_index,
    input  logic       retire_valid,
    input  rob_tag_t   retire_tag,
    input  logic       cache_busy,
    input  logic       complete_busy,
    output logic       load_req_accept,
    output logic       free_head,
    output logic       cache_req_valid,
    output logic       cache_req_is_load,
    output addr_t      cache_req_addr,
    output data_t      cache_req_data,
    output mem_size_t  cache_req_size,
    output logic       complete_valid,
    output rob_tag_t   complete_tag,
    output data_t      complete_data
);

    lsq_index_t head_idx;
    // loads already handed to the completion buffer
    lsq_mask_t  completed;
    lsq_mask_t  ready_mask;
    lsq_index_t pick;
    logic       send_complete;
    logic       load_free;
    logic       store_go;

    assign head_idx = head[LSQ_INDEX_BITS-1:0];

    // oldest finished load not yet reported
    assign ready_mask = occupied & is_load & load_done & ~completed;
    assign pick = oldest_index(ready_mask, head_idx);
    assign send_complete = !complete_busy && (|ready_mask);

    // loads own the cache port over stores
    assign load_req_accept = load_req_valid && !cache_busy;

    // head load leaves the cycle after its completion went out
    assign load_free = occupied[head_idx] && is_load[head_idx] && completed[head_idx];

    // retired store at head writes and leaves together
    assign store_go = occupied[head_idx] && !is_load[head_idx] && retire_valid
                      && retire_tag == tags[head_idx] && !load_req_valid && !cache_busy;

    assign free_head = load_free || store_go;

    // control flags and strobes
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            completed <= '0;
            complete_valid <= 1'b0;
            cache_req_valid <= 1'b0;
        end else begin
            if (alloc_strobe) begin
                completed[alloc_index] <= 1'b0;
            end
            if (send_complete) begin
                completed[pick] <= 1'b1;
            end
            complete_valid <= send_complete;
            cache_req_valid <= load_req_accept || store_go;
        end
    end

    // completion payload
    always_ff @(posedge clock) begin
        if (send_complete) begin
            complete_tag <= tags[pick];
            complete_data <= load_values[pick];
        end
    end

    // cache request payload, load or head store
    always_ff @(posedge clock) begin
        if (load_req_accept) begin
            cache_req_is_load <= 1'b1;
            cache_req_addr <= addrs[load_req_index];
            cache_req_data <= '0;
            cache_req_size <= sizes[load_req_index];
        end else if (store_go) begin
            cache_req_is_load <= 1'b0;
            cache_req_addr <= addrs[head_idx];
            cache_req_data <= store_data[head_idx];
            cache_req_size <= sizes[head_idx];
        end
    end

endmodule

// File: verilog/lsq_top.sv
module lsq_top
    import queue_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    // dispatch
    input  logic       dispatch_valid,
    input  logic       dispatch_is_load,
    input  rob_tag_t   dispatch_tag,
    output lsq_index_t dispatch_index,
    output logic       full,
    // execute
    input  logic       exec_valid,
    input  lsq_index_t exec_index,
    input  addr_t      exec_addr,
    input  mem_size_t  exec_size,
    input  data_t      exec_data,
    // retire and flush
    input  logic       retire_valid,
    input  rob_tag_t   retire_tag,
    input  logic       flush,
    // data cache request
    output logic       cache_req_valid,
    output logic       cache_req_is_load,
    output addr_t      cache_req_addr,
    output data_t      cache_req_data,
    output mem_size_t  cache_req_size,
    input  logic       cache_busy,
    // data cache response
    input  logic       cache_resp_valid,
    input  addr_t      cache_resp_addr,
    input  data_t      cache_resp_data,
    // completion buffer
    output logic       complete_valid,
    output rob_tag_t   complete_tag,
    output data_t      complete_data,
    input  logic       complete_busy
);

    // allocation, shared by every unit
    logic       alloc_strobe;
    lsq_index_t alloc_index;
    lsq_mask_t  occupied;
    lsq_mask_t  is_load;
    lsq_ptr_t   head;
    rob_tag_t [LSQ_DEPTH-1:0] tags;

    // execution results
    lsq_mask_t  addr_known;
    addr_t     [LSQ_DEPTH-1:0] addrs;
    mem_size_t [LSQ_DEPTH-1:0] sizes;
    data_t     [LSQ_DEPTH-1:0] store_data;

    // load resolution to commit
    logic       load_req_valid;
    lsq_index_t load_req_index;
    lsq_mask_t  load_done;
    data_t [LSQ_DEPTH-1:0] load_values;

    // commit back to the other units
    logic       load_req_accept;
    logic       free_head;

    lsq_dispatch dispatch_i (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .dispatch_valid   (dispatch_valid),
        .dispatch_is_load (dispatch_is_load),
        .dispatch_tag     (dispatch_tag),
        .free_head        (free_head),
        .dispatch_index   (dispatch_index),
        .full             (full),
        .alloc_strobe     (alloc_strobe),
        .alloc_index      (alloc_index),
        .occupied         (occupied),
        .is_load          (is_load),
        .head             (head),
        .tags             (tags)
    );

    lsq_address_file address_file_i (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .alloc_strobe (alloc_strobe),
        .alloc_index  (alloc_index),
        .exec_valid   (exec_valid),
        .exec_index   (exec_index),
        .exec_addr    (exec_addr),
        .exec_size    (exec_size),
        .exec_data    (exec_data),
        .addr_known   (addr_known),
        .addrs        (addrs),
        .sizes        (sizes),
        .store_data   (store_data)
    );

    lsq_load_resolve load_resolve_i (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .alloc_strobe     (alloc_strobe),
        .alloc_index      (alloc_index),
        .occupied         (occupied),
        .is_load          (is_load),
        .head             (head),
        .addr_known       (addr_known),
        .addrs            (addrs),
        .sizes            (sizes),
        .store_data       (store_data),
        .load_req_accept  (load_req_accept),
        .cache_resp_valid (cache_resp_valid),
        .cache_resp_addr  (cache_resp_addr),
        .cache_resp_data  (cache_resp_data),
        .load_req_valid   (load_req_valid),
        .load_req_index   (load_req_index),
        .load_done        (load_done),
        .load_values      (load_values)
    );

    lsq_commit commit_i (
        .clock             (clock),
        .reset             (reset),
        .flush             (flush),
        .alloc_strobe      (alloc_strobe),
        .alloc_index       (alloc_index),
        .occupied          (occupied),
        .is_load           (is_load),
        .head              (head),
        .tags              (tags),
        .addrs             (addrs),
        .sizes             (sizes),
        .store_data        (store_data),
        .load_done         (load_done),
        .load_values       (load_values),
        .load_req_valid    (load_req_valid),
        .load_req_index    (load_req_index),
        .retire_valid      (retire_valid),
        .retire_tag        (retire_tag),
        .cache_busy        (cache_busy),
        .complete_busy     (complete_busy),
        .load_req_accept   (load_req_accept),
        .free_head         (free_head),
        .cache_req_valid   (cache_req_valid),
        .cache_req_is_load (cache_req_is_load),
        .cache_req_addr    (cache_req_addr),
        .cache_req_data    (cache_req_data),
        .cache_req_size    (cache_req_size),
        .complete_valid    (complete_valid),
        .complete_tag      (complete_tag),
        .complete_data     (complete_data)
    );

endmodule

// File: test/lsq_checker.sv
module lsq_checker
    import queue_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       full,
    input  lsq_index_t dispatch_index,
    input  logic       complete_valid,
    input  logic       complete_busy,
    input  rob_tag_t   complete_tag,
    input  data_t      complete_data,
    input  logic       cache_req_valid,
    input  logic       cache_req_is_load,
    input  addr_t      cache_req_addr,
    input  data_t      cache_req_data,
    input  mem_size_t  cache_req_size,
    input  logic       retire_valid,
    input  rob_tag_t   retire_tag
);

    timeunit 1ns;
    timeprecision 100ps;

    // expected load results by rob tag
    data_t exp_data [32];
    logic  pending [32];
    // expected store writes, program order
    rob_tag_t st_tag [$];
    addr_t    st_addr [$];
    data_t    st_data [$];

    int error_count = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int pending_loads = 0;
    // high while nothing may leave the queue
    logic quiet = 1'b0;
    // inputs seen at the previous edge
    logic     prev_complete_busy;
    logic     prev_retire_valid;
    rob_tag_t prev_retire_tag;

    initial begin
        for (int i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
        end
    end

    task automatic log_error(string msg);
        $display("%s", msg);
        error_count++;
        test_errors++;
    endtask

    task automatic expect_load(rob_tag_t tag, data_t value);
        exp_data[tag] = value;
        pending[tag] = 1'b1;
        pending_loads++;
    endtask

    task automatic expect_store(rob_tag_t tag, addr_t addr, data_t value);
        st_tag.push_back(tag);
        st_addr.push_back(addr);
        st_data.push_back(value);
    endtask

    // loads not yet completed plus stores not yet written
    function automatic int outstanding();
        return pending_loads + st_tag.size();
    endfunction

    task automatic check_full(logic expected);
        if (full !== expected) begin
            log_error($sformatf("Mismatch at %0t: full is %b, expected %b", $time, full, expected));
        end
    endtask

    // slot handed back for the dispatch sampled at this edge
    task automatic check_index(lsq_index_t expected);
        if (dispatch_index !== expected) begin
            log_error($sformatf("Mismatch at %0t: dispatch index %0d, expected %0d",
                $time, dispatch_index, expected));
        end
    endtask

    task automatic set_quiet(logic q);
        quiet = q;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %0d %s: fail (%0d errors)", tests_run, name, test_errors);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
        test_errors = 0;
    endtask

    // sampled at the edge, so outputs hold the previous cycle's values
    always @(posedge clock) begin
        if (reset) begin
            prev_complete_busy = 1'b0;
            prev_retire_valid = 1'b0;
            prev_retire_tag = '0;
        end else begin
            // completion side
            if (complete_valid) begin
                if (quiet) begin
                    log_error("a completion came out of an empty, flushed queue");
                end else if (prev_complete_busy) begin
                    log_error("a completion was sent while the completion buffer was busy");
                end else if (!pending[complete_tag]) begin
                    log_error($sformatf("tag %0d completed but was not waiting", complete_tag));
                end else begin
                    if (complete_data !== exp_data[complete_tag]) begin
                        log_error($sformatf("Mismatch at %0t: load tag %0d data %h, expected %h",
                            $time, complete_tag, complete_data, exp_data[complete_tag]));
                    end
                    pending[complete_tag] = 1'b0;
                    pending_loads--;
                end
            end
            // cache side
            if (cache_req_valid && quiet) begin
                log_error("a cache request came out of an empty, flushed queue");
            end else if (cache_req_valid && !cache_req_is_load) begin
                if (st_tag.size() == 0) begin
                    log_error("a store write appeared with no store waiting to retire");
                end else begin
                    if (!prev_retire_valid || prev_retire_tag != st_tag[0]) begin
                        log_error($sformatf("store tag %0d was written before its retire", st_tag[0]));
                    end
                    if (cache_req_addr !== st_addr[0] || cache_req_data !== st_data[0]) begin
                        log_error($sformatf("Mismatch at %0t: store %h=%h, expected %h=%h", $time,
                            cache_req_addr, cache_req_data, st_addr[0], st_data[0]));
                    end
                    void'(st_tag.pop_front());
                    void'(st_addr.pop_front());
                    void'(st_data.pop_front());
                end
            end
            if (cache_req_valid && cache_req_size !== 2'b10) begin
                log_error($sformatf("Mismatch at %0t: request size %b, expected 10",
                    $time, cache_req_size));
            end
            prev_complete_busy = complete_busy;
            prev_retire_valid = retire_valid;
            prev_retire_tag = retire_tag;
        end
    end

endmodule

// File: test/tb_lsq_top.sv
module tb_lsq_top
    import queue_pkg::*;
    import mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 8;
    localparam int CYCLE_LIMIT = 400 * NUM_TESTS;
    localparam int MEM_WORDS = 16;
    localparam int MAX_OPS = 64;
    localparam addr_t BASE = 32'h0000_0100;

    logic       clock;
    logic       reset;
    logic       dispatch_valid;
    logic       dispatch_is_load;
    rob_tag_t   dispatch_tag;
    lsq_index_t dispatch_index;
    logic       full;
    logic       exec_valid;
    lsq_index_t exec_index;
    addr_t      exec_addr;
    mem_size_t  exec_size;
    data_t      exec_data;
    logic       retire_valid;
    rob_tag_t   retire_tag;
    logic       flush;
    logic       cache_req_valid;
    logic       cache_req_is_load;
    addr_t      cache_req_addr;
    data_t      cache_req_data;
    mem_size_t  cache_req_size;
    logic       cache_busy;
    logic       cache_resp_valid;
    addr_t      cache_resp_addr;
    data_t      cache_resp_data;
    logic       complete_valid;
    rob_tag_t   complete_tag;
    data_t      complete_data;
    logic       complete_busy;

    // program, in order, flushed ops marked dead
    logic       op_is_load [MAX_OPS];
    addr_t      op_addr [MAX_OPS];
    data_t      op_data [MAX_OPS];
    logic       op_live [MAX_OPS];
    lsq_index_t op_slot [MAX_OPS];
    int         num_ops = 0;
    int         tail_count = 0;
    int         cycles = 0;
    logic [31:0] rng_prog;
    logic [31:0] rng_busy;

    // cache model, one stage between request and response
    data_t mem [MEM_WORDS];
    logic  s0_valid;
    addr_t s0_addr;
    data_t s0_data;

    lsq_top dut_i (.*);

    lsq_checker lsq_checker_i (.*);

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fill pattern, every address bit matters
    function automatic data_t init_word(addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // walk live ops in order over the initial memory
    function automatic data_t expected_value(int k);
        data_t v;
        v = init_word(op_addr[k]);
        for (int j = 0; j < k; j++) begin
            if (op_live[j] && !op_is_load[j] && op_addr[j] == op_addr[k]) begin
                v = op_data[j];
            end
        end
        return v;
    endfunction

    task automatic add_op(logic is_load, int word, data_t value, logic live);
        op_is_load[num_ops] = is_load;
        op_addr[num_ops] = BASE + addr_t'(word * 4);
        op_data[num_ops] = value;
        op_live[num_ops] = live;
        num_ops++;
    endtask

    task automatic add_random_op(logic live);
        rng_prog = xorshift(rng_prog);
        add_op(rng_prog[0], int'(rng_prog[4:1]), xorshift(rng_prog ^ 32'h55aa), live);
    endtask

    task automatic dispatch_ops(int first, int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            // previous op is being taken at this edge
            if (i > 0) begin
                lsq_checker_i.check_index(op_slot[first + i - 1]);
            end
            dispatch_valid <= 1'b1;
            dispatch_is_load <= op_is_load[first + i];
            dispatch_tag <= rob_tag_t'(first + i);
            op_slot[first + i] = lsq_index_t'(tail_count);
            tail_count++;
        end
        @(posedge clock);
        lsq_checker_i.check_index(op_slot[first + count - 1]);
        dispatch_valid <= 1'b0;
    endtask

    task automatic exec_op(int k);
        @(posedge clock);
        exec_valid <= 1'b1;
        exec_index <= op_slot[k];
        exec_addr <= op_addr[k];
        exec_size <= 2'b10;
        exec_data <= op_data[k];
    endtask

    // dispatch, execute, retire stores, then wait for the queue to drain
    task automatic run_batch(int first, int count, logic shuffle);
        int order [LSQ_DEPTH];
        int j;
        int tmp;
        for (int i = 0; i < count; i++) begin
            if (op_is_load[first + i]) begin
                lsq_checker_i.expect_load(rob_tag_t'(first + i), expected_value(first + i));
            end else begin
                lsq_checker_i.expect_store(rob_tag_t'(first + i), op_addr[first + i],
                    op_data[first + i]);
            end
        end
        dispatch_ops(first, count);
        if (count == LSQ_DEPTH) begin
            @(posedge clock);
            lsq_checker_i.check_full(1'b1);
        end
        // reverse order unless shuffled, so later addresses arrive first
        for (int i = 0; i < count; i++) begin
            order[i] = first + count - 1 - i;
        end
        if (shuffle) begin
            for (int i = count - 1; i > 0; i--) begin
                rng_prog = xorshift(rng_prog);
                j = int'(rng_prog % (i + 1));
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
        for (int i = 0; i < count; i++) begin
            exec_op(order[i]);
        end
        @(posedge clock);
        exec_valid <= 1'b0;
        // retire stores in program order, hold until the write goes out
        for (int i = first; i < first + count; i++) begin
            if (!op_is_load[i]) begin
                retire_valid <= 1'b1;
                retire_tag <= rob_tag_t'(i);
                do begin
                    @(posedge clock);
                end while (!(cache_req_valid && !cache_req_is_load));
            end
        end
        retire_valid <= 1'b0;
        while (lsq_checker_i.outstanding() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        if (count == LSQ_DEPTH) begin
            lsq_checker_i.check_full(1'b0);
        end
    endtask

    // loads sit behind a store with no address, then everything is flushed
    task automatic flush_queue();
        int first;
        first = num_ops;
        add_op(1'b0, 0, 32'hdead_beef, 1'b0);
        // one load would forward, two would go to the cache
        for (int i = 0; i < 3; i++) begin
            add_op(1'b1, i, '0, 1'b0);
        end
        lsq_checker_i.set_quiet(1'b1);
        dispatch_ops(first, 4);
        for (int i = 1; i < 4; i++) begin
            exec_op(first + i);
        end
        @(posedge clock);
        exec_valid <= 1'b0;
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        tail_count = 0;
        // store address shows up late, the flushed loads must stay gone
        exec_op(first);
        @(posedge clock);
        exec_valid <= 1'b0;
        repeat (20) @(posedge clock);
        lsq_checker_i.set_quiet(1'b0);
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // cache model and busy levels
    always @(posedge clock) begin
        if (reset) begin
            s0_valid <= 1'b0;
            cache_resp_valid <= 1'b0;
            cache_busy <= 1'b0;
            complete_busy <= 1'b0;
        end else begin
            rng_busy <= xorshift(rng_busy);
            cache_busy <= (rng_busy[3:2] == 2'b00);
            complete_busy <= (rng_busy[7:6] == 2'b00);
            s0_valid <= cache_req_valid && cache_req_is_load;
            s0_addr <= cache_req_addr;
            s0_data <= mem[cache_req_addr[5:2]];
            if (cache_req_valid && !cache_req_is_load) begin
                mem[cache_req_addr[5:2]] <= cache_req_data;
            end
            cache_resp_valid <= s0_valid;
            cache_resp_addr <= s0_addr;
            cache_resp_data <= s0_data;
        end
    end

    // run limit
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int first;
        int count;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_is_load = 1'b0;
        dispatch_tag = '0;
        exec_valid = 1'b0;
        exec_index = '0;
        exec_addr = '0;
        exec_size = '0;
        exec_data = '0;
        retire_valid = 1'b0;
        retire_tag = '0;
        flush = 1'b0;
        cache_busy = 1'b0;
        cache_resp_valid = 1'b0;
        cache_resp_addr = '0;
        cache_resp_data = '0;
        complete_busy = 1'b0;
        rng_prog = 32'd65;
        rng_busy = xorshift(32'd65);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = init_word(BASE + addr_t'(i * 4));
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // load address known before the store's
        add_op(1'b0, 3, 32'h1234_5678, 1'b1);
        add_op(1'b1, 3, '0, 1'b1);
        run_batch(0, 2, 1'b0);
        lsq_checker_i.end_test("store to load forwarding");

        add_op(1'b1, 5, '0, 1'b1);
        run_batch(2, 1, 1'b1);
        lsq_checker_i.end_test("load from cache");

        first = num_ops;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            add_random_op(1'b1);
        end
        run_batch(first, LSQ_DEPTH, 1'b1);
        lsq_checker_i.end_test("full flag");

        flush_queue();
        lsq_checker_i.end_test("flush");

        for (int t = 0; t < 4; t++) begin
            rng_prog = xorshift(rng_prog);
            count = int'(rng_prog[2:0]) + 1;
            first = num_ops;
            for (int i = 0; i < count; i++) begin
                add_random_op(1'b1);
            end
            run_batch(first, count, 1'b1);
            lsq_checker_i.end_test($sformatf("random batch %0d", t));
        end

        $display("tests run %0d, failed %0d, errors %0d", lsq_checker_i.tests_run,
            lsq_checker_i.tests_failed, lsq_checker_i.error_count);
        if (lsq_checker_i.tests_failed == 0 && lsq_checker_i.error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: lsq_top.f
verilog/mem_pkg.sv
verilog/queue_pkg.sv
verilog/lsq_dispatch.sv
verilog/lsq_address_file.sv
verilog/lsq_load_resolve.sv
verilog/lsq_commit.sv
verilog/lsq_top.sv
test/lsq_checker.sv
test/tb_lsq_top.sv
